// ==== Bender.yml ====
package:
  name: flash_qspi_read

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/flash_pkg.sv
      - source/flash_qspi_reader.sv
      - source/flash_io_stage.sv
      - source/flash_subsystem.sv
      - target: test
        files:
          - dv/flash_model.sv
          - dv/flash_props.sv
          - dv/flash_tb.sv

// ==== dv/flash_model.sv ====
/*
 * Behavioral quad-output flash answering the 0x6B fast read
 * Content follows a fixed rule on the byte address, nothing is stored
 */

`timescale 1ns/1ns

module flash_model (
    input  logic       pin_clk,
    input  logic       pin_csn,
    input  logic [3:0] pin_oe,
    input  logic [3:0] pin_do,
    output logic [3:0] pin_di
);

    // Clock positions within one chip select period
    localparam int TX_CLKS = 32;
    localparam int DATA_FIRST = 40;
    localparam int DATA_END = 48;

    // Flash clocks seen since chip select fell
    int          clk_cnt;
    // Command byte followed by the byte address, MSB first
    logic [31:0] shift_in;
    logic [7:0]  byte_val;
    int          nib;

    // Byte a holds a * 37 + 11 xor the bits of a from bit 8 up, low eight bits kept
    function automatic logic [7:0] stored_byte(input logic [23:0] a);
        logic [31:0] mix;
        mix = (32'(a) * 37 + 11) ^ (32'(a) >> 8);
        return mix[7:0];
    endfunction

    initial begin
        clk_cnt = 0;
        pin_di  = 'z;
    end

    // io0 is read on the falling clock edge, in the middle of the pin cycle
    // Data goes out on the falling edge too and is picked up at the next clk_2x edge
    always @(negedge pin_clk or posedge pin_csn) begin
        if (pin_csn !== 1'b0) begin
            clk_cnt <= 0;
            pin_di  <= 'z;
        end else begin
            if (clk_cnt < TX_CLKS) begin
                // A bit that the host does not drive is taken as unknown
                shift_in <= {shift_in[30:0], pin_oe[0] ? pin_do[0] : 1'bx};
            end
            if (clk_cnt >= DATA_FIRST && clk_cnt < DATA_END) begin
                nib = clk_cnt - DATA_FIRST;
                byte_val = stored_byte(shift_in[23:0] + 24'(nib / 2));
                // Anything but the quad fast read gets garbage back
                if (shift_in[31:24] !== 8'h6B) begin
                    pin_di <= 'x;
                end else begin
                    pin_di <= nib[0] ? byte_val[3:0] : byte_val[7:4];
                end
            end
            clk_cnt <= clk_cnt + 1;
        end
    end

endmodule

// ==== dv/flash_props.sv ====
/*
 * Concurrent checks on the Wishbone handshake and the flash pins
 * Keeps a count of failed assertions for the testbench to look at
 * Bound into the flash_subsystem top level
 */

`timescale 1ns/1ns

module flash_props (
    input logic       clk_2x,
    input logic       rst,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       pin_csn,
    input logic [3:0] pin_oe
);

    // Number of assertion failures seen so far
    int failures = 0;

    // Acknowledge is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk_2x) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack stayed high for more than one cycle");
            failures = failures + 1;
        end

    // The flash is deselected whenever no request is on the bus
    csn_idle_high: assert property (@(posedge clk_2x) disable iff (rst)
        !(wb_cyc && wb_stb) |-> pin_csn)
        else begin
            $error("pin_csn low while no transfer is active");
            failures = failures + 1;
        end

    // The flash drives io from the first data clock, 40 cycles into the select,
    // until chip select rises ten cycles later
    oe_off_while_flash_drives: assert property (@(posedge clk_2x) disable iff (rst)
        $fell(pin_csn) |-> ##40 (pin_oe == 4'b0000) [*10])
        else begin
            $error("pin_oe not released while the flash drives data");
            failures = failures + 1;
        end

    ack_needs_request: assert property (@(posedge clk_2x) disable iff (rst)
        $rose(wb_ack) |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack rose without cyc and stb");
            failures = failures + 1;
        end

endmodule

bind flash_subsystem flash_props props (
    .clk_2x  (clk_2x),
    .rst     (rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .pin_csn (pin_csn),
    .pin_oe  (pin_oe)
);

// ==== dv/flash_tb.sv ====
/*
 * Testbench for the quad-SPI flash read port with a behavioral flash on the pins
 * Wishbone master, content reference, read checker, flash clock counter, watchdog
 */

`timescale 1ns/1ns
`include "flash_defines.svh"

module flash_tb import flash_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_READS = 40;
    // Three fixed reads, the random reads, a write with its read-back, a back-to-back pair
    localparam int NUM_XFERS = 3 + RANDOM_READS + 2 + 2;
    localparam int NUM_READS = NUM_XFERS - 1;
    localparam int XFER_CYCLES = 60;
    // Command, address, dummy and data clocks of one fast read
    localparam int READ_CLKS = 8 + `FLASH_ADDR_BITS + `FLASH_DUMMY_CLKS + 8;

    logic          clk_2x;
    logic          rst;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    wb_word_addr_t wb_adr;
    flash_word_t   wb_dat_w;
    logic          wb_ack;
    flash_word_t   wb_dat_r;
    logic          pin_clk;
    logic          pin_csn;
    logic [3:0]    pin_oe;
    flash_nibble_t pin_do;
    flash_nibble_t pin_di;

    logic [31:0]   lcg_state;
    int            reads_checked;
    int            clk_edges;
    logic          last_pin_clk;

    flash_subsystem DUT (.*);

    flash_model flash (.*);

    // Byte a holds a * 37 + 11 xor the bits of a from bit 8 up, low eight bits kept
    function automatic logic [7:0] content_byte(input logic [23:0] a);
        logic [31:0] mix;
        mix = (32'(a) * 37 + 11) ^ (32'(a) >> 8);
        return mix[7:0];
    endfunction

    // Expected read data, lowest byte address in bits 7:0
    function automatic flash_word_t expected_word(input wb_word_addr_t adr);
        flash_byte_addr_t base;
        base = {adr, 2'b00};
        return {content_byte(base + 24'd3), content_byte(base + 24'd2),
                content_byte(base + 24'd1), content_byte(base)};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error @ %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One classic cycle, held until ack, then stb drops for at least one cycle
    task automatic wb_transfer(input logic we, input wb_word_addr_t adr, input logic keep_cyc);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        // Write data differs from the content so that a stored write would show up
        wb_dat_w <= ~expected_word(adr);
        @(posedge clk_2x);
        while (!wb_ack) begin
            @(posedge clk_2x);
        end
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        wb_cyc <= keep_cyc;
        @(posedge clk_2x);
    endtask

    initial begin
        clk_2x = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_2x = ~clk_2x;
        end
    end

    // pin_clk is looked at a quarter period after each clk_2x edge, where it is settled
    always @(clk_2x) begin
        #(CLK_PERIOD / 4);
        if (pin_clk === 1'b1 && last_pin_clk === 1'b0) begin
            clk_edges = clk_edges + 1;
        end
        last_pin_clk = pin_clk;
    end

    // Every acknowledged read is compared with the reference word
    // A write must not clock the flash at all
    always @(posedge clk_2x) begin
        if (!rst) begin
            if (wb_ack) begin
                if (!wb_we) begin
                    check_value("wb_dat_r", wb_dat_r, expected_word(wb_adr));
                    reads_checked <= reads_checked + 1;
                end
                check_value("pin_clk rising edges", clk_edges, wb_we ? 0 : READ_CLKS);
                clk_edges <= 0;
            end
            if (!(wb_cyc && wb_stb)) begin
                check_value("pin_csn", pin_csn, 1);
            end
            // Any failed protocol assertion in the bound checker ends the run
            check_value("protocol assertion failures", DUT.props.failures, 0);
        end
    end

    initial begin
        rst           = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        lcg_state     = 32'd42;
        reads_checked = 0;
        clk_edges     = 0;
        last_pin_clk  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_2x);
        rst <= 1'b0;
        // Idle pin state right after reset
        @(posedge clk_2x);
        #(CLK_PERIOD / 4);
        check_value("wb_ack", wb_ack, 0);
        check_value("pin_csn", pin_csn, 1);
        check_value("pin_oe", pin_oe, 0);
        check_value("pin_clk", pin_clk, 0);
        @(posedge clk_2x);
        // First word, second word and the top word of the flash
        wb_transfer(1'b0, 22'h000000, 1'b0);
        wb_transfer(1'b0, 22'h000001, 1'b0);
        wb_transfer(1'b0, 22'h3FFFFF, 1'b0);
        repeat (RANDOM_READS) begin
            lcg_state = lcg_next(lcg_state);
            wb_transfer(1'b0, lcg_state[31:10], 1'b0);
        end
        // A write is only acknowledged, the read-back sees the original content
        wb_transfer(1'b1, 22'h0002A5, 1'b0);
        wb_transfer(1'b0, 22'h0002A5, 1'b0);
        // cyc stays high and stb drops for a single cycle between the reads
        wb_transfer(1'b0, 22'h001234, 1'b1);
        wb_transfer(1'b0, 22'h001235, 1'b0);
        repeat (2) @(posedge clk_2x);
        #(CLK_PERIOD / 4);
        if (reads_checked != NUM_READS) begin
            $display("Only %0d of %0d reads were acknowledged and checked",
                     reads_checked, NUM_READS);
            $display("Test failures found");
            $fatal(1, "Read count wrong");
        end else if (DUT.props.failures != 0) begin
            $display("%0d protocol assertions failed", DUT.props.failures);
            $display("Test failures found");
            $fatal(1, "Protocol assertion failed");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    // Budget of 60 cycles per transfer on top of reset
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 4 + XFER_CYCLES * NUM_XFERS));
        $display("The run hung, a Wishbone acknowledge never arrived in time");
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== list.f ====
+incdir+source
source/flash_pkg.sv
source/flash_qspi_reader.sv
source/flash_io_stage.sv
source/flash_subsystem.sv
dv/flash_model.sv
dv/flash_props.sv
dv/flash_tb.sv

// ==== source/flash_defines.svh ====
/*
 * Macros for the quad-SPI flash read port
 * Fast-read command code, dummy clock count and flash byte address width
 */

`ifndef FLASH_DEFINES_SVH
`define FLASH_DEFINES_SVH

// Quad-output fast read, command on io0 and data back on io[3:0]
`define FLASH_CMD_QREAD 8'h6B

// Flash clocks between the last address bit and the first data nibble
`define FLASH_DUMMY_CLKS 8

// Flash byte address width, three address bytes on the wire
`define FLASH_ADDR_BITS 24

`endif

// ==== source/flash_io_stage.sv ====
/*
 * Registered pin stage between the flash reader and the flash pins
 * Builds the flash clock from a rising and a falling edge flop, like SB_IO DDR
 */

`timescale 1ns/1ns

module flash_io_stage import flash_pkg::*; (
    input  logic          clk_2x,
    input  logic          rst,

    input  logic [1:0]    flash_clk_ddr,
    input  logic          flash_csn,
    input  logic [3:0]    flash_oe,
    input  flash_nibble_t flash_do,
    output flash_nibble_t flash_di,

    output logic          pin_clk,
    output logic          pin_csn,
    output logic [3:0]    pin_oe,
    output flash_nibble_t pin_do,
    input  flash_nibble_t pin_di
);

    // Half-cycle copies of the DDR clock pair
    logic clk_rise_q;
    logic clk_fall_q;

    // Control pins come out of reset with the flash deselected and io released
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            pin_csn    <= 1'b1;
            pin_oe     <= 4'b0000;
            clk_rise_q <= 1'b0;
        end else begin
            pin_csn    <= flash_csn;
            pin_oe     <= flash_oe;
            clk_rise_q <= flash_clk_ddr[0];
        end
    end

    // Data in both directions is registered once on the rising edge
    always_ff @(posedge clk_2x) begin
        pin_do   <= flash_do;
        flash_di <= pin_di;
    end

    // Second half of the clk_2x cycle takes bit 1 of the pair
    always_ff @(negedge clk_2x) begin
        if (rst) begin
            clk_fall_q <= 1'b0;
        end else begin
            clk_fall_q <= flash_clk_ddr[1];
        end
    end

    // Bit 0 drives the pin while clk_2x is high and bit 1 while it is low
    assign pin_clk = clk_2x ? clk_rise_q : clk_fall_q;

endmodule

// ==== source/flash_pkg.sv ====
/*
 * Shared types for the quad-SPI flash read port
 * Address, word and nibble vectors and the reader state encoding
 */

`include "flash_defines.svh"

package flash_pkg;

    // Byte address exactly as it is shifted out to the flash
    typedef logic [`FLASH_ADDR_BITS-1:0] flash_byte_addr_t;

    // Wishbone addresses whole words, so the two byte select bits are gone
    typedef logic [`FLASH_ADDR_BITS-3:0] wb_word_addr_t;

    // Byte at the lowest flash address lives in bits 7:0
    typedef logic [31:0] flash_word_t;

    // One value of the io[3:0] bus
    typedef logic [3:0] flash_nibble_t;

    // Sequencer states of the fast-read reader
    typedef enum logic [2:0] {IDLE, CMD, ADDR, DUMMY, DATA, ACK} reader_state_t;

endpackage

// ==== source/flash_qspi_reader.sv ====
/*
 * Wishbone classic slave for word reads from a quad-SPI flash
 * Sequences command 0x6B, the byte address, dummy clocks and eight data nibbles
 * Writes are acknowledged one cycle after the request and otherwise dropped
 */

`timescale 1ns/1ns
`include "flash_defines.svh"

module flash_qspi_reader import flash_pkg::*; (
    input  logic          clk_2x,
    input  logic          rst,

    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  wb_word_addr_t wb_adr,
    input  flash_word_t   wb_dat_w,
    output logic          wb_ack,
    output flash_word_t   wb_dat_r,

    output logic [1:0]    flash_clk_ddr,
    output logic          flash_csn,
    output logic [3:0]    flash_oe,
    output flash_nibble_t flash_do,
    input  flash_nibble_t flash_di
);

    // Command byte length in single-bit clocks
    localparam int CMD_BITS = 8;
    // One nibble per clock fills a 32-bit word in eight clocks
    localparam int DATA_CLKS = 8;
    // Output register plus input register between the reader and the flash
    localparam int RTRIP = 2;
    // Data phase keeps going until the last nibble has come back
    localparam int DATA_LAST = DATA_CLKS + RTRIP - 1;
    localparam int TX_BITS = CMD_BITS + `FLASH_ADDR_BITS;

    reader_state_t        state;
    logic [4:0]           bit_cnt;
    logic [TX_BITS-1:0]   tx_sr;
    flash_word_t          rx_sr;
    flash_byte_addr_t     byte_addr;
    logic                 req;
    logic                 clk_on;

    // A classic cycle is requested while both cyc and stb are high
    assign req = wb_cyc && wb_stb;

    // Word address to byte address, the word is 4-byte aligned
    assign byte_addr = {wb_adr, 2'b00};

    // Sequencer state and the per-phase clock counter
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    // The write data on wb_dat_w has nowhere to go and is ignored
                    if (req) begin
                        state <= wb_we ? ACK : CMD;
                    end
                end
                CMD: begin
                    if (bit_cnt == 5'(CMD_BITS - 1)) begin
                        state   <= ADDR;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                end
                ADDR: begin
                    if (bit_cnt == 5'(`FLASH_ADDR_BITS - 1)) begin
                        state   <= DUMMY;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                end
                DUMMY: begin
                    if (bit_cnt == 5'(`FLASH_DUMMY_CLKS - 1)) begin
                        state   <= DATA;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                end
                DATA: begin
                    // Clocks stop after DATA_CLKS but the counter runs on
                    // until the round trip has delivered the last nibble
                    if (bit_cnt == 5'(DATA_LAST)) begin
                        state   <= ACK;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                end
                ACK: begin
                    // Master drops stb now, so go straight back to idle
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Command and address go out MSB first on io0
    // The register is loaded while idle and shifted once per clock
    always_ff @(posedge clk_2x) begin
        if (state == IDLE) begin
            tx_sr <= {`FLASH_CMD_QREAD, byte_addr};
        end else if (state == CMD || state == ADDR) begin
            tx_sr <= {tx_sr[TX_BITS-2:0], 1'b0};
        end
    end

    // Nibbles arrive RTRIP cycles after the clock that produced them
    // High nibble of a byte comes first and the lowest byte comes first,
    // so the register ends up holding the bytes in big-endian order
    always_ff @(posedge clk_2x) begin
        if (state == DATA && bit_cnt >= 5'(RTRIP)) begin
            rx_sr <= {rx_sr[27:0], flash_di};
        end
    end

    // Byte swap so that the lowest flash address lands in bits 7:0
    assign wb_dat_r = {rx_sr[7:0], rx_sr[15:8], rx_sr[23:16], rx_sr[31:24]};

    assign wb_ack = (state == ACK);

    // One flash clock per cycle through command, address, dummy and data
    always_comb begin
        case (state)
            CMD, ADDR, DUMMY: clk_on = 1'b1;
            DATA:             clk_on = (bit_cnt < 5'(DATA_CLKS));
            default:          clk_on = 1'b0;
        endcase
    end

    // DDR value 01 means high in the first half of clk_2x and low in the second
    assign flash_clk_ddr = clk_on ? 2'b01 : 2'b00;

    // Chip select is released in the ack cycle, ending the flash transaction
    assign flash_csn = (state == IDLE) || (state == ACK);

    // Only io0 is driven, and only while command and address are shifted
    assign flash_oe = (state == CMD || state == ADDR) ? 4'b0001 : 4'b0000;

    assign flash_do = {3'b000, tx_sr[TX_BITS-1]};

endmodule

// ==== source/flash_subsystem.sv ====
/*
 * Quad-SPI flash read port top level
 * Wishbone reader feeding the registered flash pin stage
 */

`timescale 1ns/1ns

module flash_subsystem import flash_pkg::*; (
    input  logic          clk_2x,
    input  logic          rst,

    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  wb_word_addr_t wb_adr,
    input  flash_word_t   wb_dat_w,
    output logic          wb_ack,
    output flash_word_t   wb_dat_r,

    output logic          pin_clk,
    output logic          pin_csn,
    output logic [3:0]    pin_oe,
    output flash_nibble_t pin_do,
    input  flash_nibble_t pin_di
);

    // Reader side of the pin stage, one clk_2x cycle ahead of the pins
    logic [1:0]    flash_clk_ddr;
    logic          flash_csn;
    logic [3:0]    flash_oe;
    flash_nibble_t flash_do;
    flash_nibble_t flash_di;

    flash_qspi_reader reader (
        .clk_2x        (clk_2x),
        .rst           (rst),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_ack        (wb_ack),
        .wb_dat_r      (wb_dat_r),
        .flash_clk_ddr (flash_clk_ddr),
        .flash_csn     (flash_csn),
        .flash_oe      (flash_oe),
        .flash_do      (flash_do),
        .flash_di      (flash_di)
    );

    // Pin registers and DDR clock generation
    flash_io_stage io_stage (
        .clk_2x        (clk_2x),
        .rst           (rst),
        .flash_clk_ddr (flash_clk_ddr),
        .flash_csn     (flash_csn),
        .flash_oe      (flash_oe),
        .flash_do      (flash_do),
        .flash_di      (flash_di),
        .pin_clk       (pin_clk),
        .pin_csn       (pin_csn),
        .pin_oe        (pin_oe),
        .pin_do        (pin_do),
        .pin_di        (pin_di)
    );

endmodule
